/* flist.f */
tspp_pkg.sv
tspp_branch_predictor.sv
tspp_fetch_stage.sv
tspp_hazard_unit.sv
tspp_execute_stage.sv
tspp_core.sv
tb_tspp_core.sv

/* tb_tspp_core.sv */
`timescale 1ns/10ps

module tb_tspp_core;
  import tspp_pkg::*;

  localparam int N_RETIRE     = 400;
  // two fetches of up to four cycles each per retire at worst
  localparam int MAX_CYCLES   = N_RETIRE * 8;
  localparam int RESET_CYCLES = 2;
  localparam int MAIN_WORDS   = 64;
  localparam int TRAP_WORDS   = 8;
  localparam logic [15:0] LFSR_SEED = 16'd11;
  // loop counter kept apart from the random data regs x0..x7
  localparam regidx_t CNT_REG = 5'd15;

  logic    CLK;
  logic    nRST;
  addr_t   ibus_addr;
  logic    ibus_ren;
  word_t   ibus_rdata = NOP_INSTR;
  logic    ibus_busy = 1'b0;
  retire_t retire;

  word_t       main_mem [MAIN_WORDS];
  word_t       trap_mem [TRAP_WORDS];
  logic [15:0] lfsr;

  // memory model request state
  addr_t      req_addr = RESET_PC;
  logic       req_done = 1'b1;
  logic [1:0] wait_left = 2'd0;

  // ISA model state
  addr_t   ref_pc = RESET_PC;
  word_t   ref_regs [32];
  retire_t exp_rec;
  int      neg_count = 0;
  int      n_retired = 0;
  logic    done = 1'b0;

  tspp_core i_dut (
    .CLK        (CLK),
    .nRST       (nRST),
    .ibus_addr  (ibus_addr),
    .ibus_ren   (ibus_ren),
    .ibus_rdata (ibus_rdata),
    .ibus_busy  (ibus_busy),
    .retire     (retire)
  );

  initial begin
    CLK = 1'b1;
    forever #4 CLK = ~CLK;
  end

  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // instruction encoders with funct3 zero where not given
  function automatic word_t i_format(logic [11:0] imm, regidx_t rs1, regidx_t rd, opcode_t op);
    return {imm, rs1, 3'b000, rd, op};
  endfunction

  function automatic word_t r_format(logic [6:0] f7, regidx_t rs2, regidx_t rs1, regidx_t rd);
    return {f7, rs2, rs1, 3'b000, rd, OP_REG};
  endfunction

  function automatic word_t u_format(logic [19:0] imm, regidx_t rd);
    return {imm, rd, OP_LUI};
  endfunction

  function automatic word_t b_format(logic [12:0] off, regidx_t rs2, regidx_t rs1,
                                     logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic word_t j_format(regidx_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  // program and trap windows while anything else jumps home
  function automatic word_t mem_word(addr_t a);
    if (a >= RESET_PC && a < RESET_PC + 4 * MAIN_WORDS) begin
      return main_mem[(a - RESET_PC) >> 2];
    end else if (a >= TRAP_PC && a < TRAP_PC + 4 * TRAP_WORDS) begin
      return trap_mem[(a - TRAP_PC) >> 2];
    end
    return j_format(5'd0, 21'(RESET_PC - a));
  endfunction

  task automatic build_program();
    int          i;
    logic [2:0]  kind;
    regidx_t     rd;
    regidx_t     rs1;
    regidx_t     rs2;
    logic [11:0] imm;
    logic [2:0]  f3;
    addr_t       tgt;
    for (int k = 0; k < MAIN_WORDS; k++) main_mem[k] = NOP_INSTR;
    for (int k = 0; k < TRAP_WORDS; k++) trap_mem[k] = NOP_INSTR;
    i = 0;
    while (i < MAIN_WORDS) begin
      kind = 3'(draw_bits(3));
      rd   = regidx_t'(draw_bits(3));
      rs1  = regidx_t'(draw_bits(3));
      rs2  = regidx_t'(draw_bits(3));
      imm  = 12'(draw_bits(12));
      case (kind)
        3'd2: main_mem[i] = r_format(F7_ADD, rs2, rs1, rd);
        3'd3: main_mem[i] = r_format(F7_SUB, rs2, rs1, rd);
        3'd4: main_mem[i] = u_format({imm, imm[7:0]}, rd);
        3'd5: begin
          // short forward branch two to five words ahead
          f3 = (imm[1:0] == 2'd0) ? F3_BEQ : (imm[1:0] == 2'd1) ? F3_BNE : F3_BLT;
          main_mem[i] = b_format(13'd8 + {9'd0, imm[3:2], 2'b00}, rs2, rs1, f3);
        end
        3'd6: begin
          if (i + 4 <= MAIN_WORDS) begin
            // counted loop where blt x0,x15 exits once the counter drops to zero
            main_mem[i]     = i_format({10'd0, imm[1:0]} + 12'd2, 5'd0, CNT_REG, OP_IMM);
            main_mem[i + 1] = i_format(imm, rd, rd, OP_IMM);
            main_mem[i + 2] = i_format(12'hfff, CNT_REG, CNT_REG, OP_IMM);
            main_mem[i + 3] = b_format(13'h1ff8, CNT_REG, 5'd0, F3_BLT);
            i = i + 3;
          end else begin
            main_mem[i] = i_format(imm, rs1, rd, OP_IMM);
          end
        end
        3'd7: begin
          if (imm[4]) begin
            main_mem[i] = j_format(rd, 21'd8 + {17'd0, imm[3:2], 2'b00});
          end else begin
            // absolute target off x0 where offset 2 leaves it misaligned
            tgt = RESET_PC + 4 * (i + 2 + imm[3:2]) + ((imm[1:0] == 2'b11) ? 2 : imm[0]);
            main_mem[i] = i_format(tgt[11:0], 5'd0, rd, OP_JALR);
          end
        end
        default: main_mem[i] = i_format(imm, rs1, rd, OP_IMM);
      endcase
      i = i + 1;
    end
    // handler runs a few addis then jumps back to the program start
    for (int k = 0; k < 4; k++) begin
      imm         = 12'(draw_bits(12));
      trap_mem[k] = i_format(imm, regidx_t'(k + 1), regidx_t'(k + 1), OP_IMM);
    end
    trap_mem[4] = j_format(5'd0, 21'(RESET_PC - (TRAP_PC + 32'd16)));
  endtask

  // one ISA step that returns what the retire port should show
  function automatic retire_t ref_step();
    retire_t r;
    word_t   ins;
    word_t   a;
    word_t   b;
    word_t   val;
    addr_t   npc;
    logic    wr;
    logic    tk;
    r       = '0;
    ins     = mem_word(ref_pc);
    r.valid = 1'b1;
    r.pc    = ref_pc;
    r.instr = ins;
    npc     = ref_pc + 32'd4;
    wr      = 1'b0;
    tk      = 1'b0;
    val     = '0;
    a       = ref_regs[ins[19:15]];
    b       = ref_regs[ins[24:20]];
    if (ref_pc[1:0] != 2'b00) begin
      // misaligned fetch only enters the handler
      r.trap = 1'b1;
      npc    = TRAP_PC;
    end else begin
      case (ins[6:0])
        OP_IMM: begin
          wr  = (ins[14:12] == 3'b000);
          val = a + {{20{ins[31]}}, ins[31:20]};
        end
        OP_REG: begin
          wr  = (ins[14:12] == 3'b000) && (ins[31:25] == F7_ADD || ins[31:25] == F7_SUB);
          val = (ins[31:25] == F7_SUB) ? a - b : a + b;
        end
        OP_LUI: begin
          wr  = 1'b1;
          val = {ins[31:12], 12'h000};
        end
        OP_BRANCH: begin
          tk = (ins[14:12] == F3_BEQ && a == b) || (ins[14:12] == F3_BNE && a != b) ||
               (ins[14:12] == F3_BLT && $signed(a) < $signed(b));
          if (tk) npc = ref_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        OP_JAL: begin
          wr  = 1'b1;
          val = ref_pc + 32'd4;
          npc = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        OP_JALR: begin
          if (ins[14:12] == 3'b000) begin
            wr  = 1'b1;
            val = ref_pc + 32'd4;
            npc = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
          end
        end
        default: ;
      endcase
    end
    // x0 stays zero and the record shows no write
    if (wr && ins[11:7] != 5'd0) begin
      ref_regs[ins[11:7]] = val;
      r.rd                = ins[11:7];
      r.rd_data           = val;
    end
    ref_pc = npc;
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, want);
      $display(">>> FAIL");
      $fatal(1, "retire record differs from the ISA model");
    end
  endtask

  // wait-state memory with a fresh 0..3 cycle wait per new request
  always @(negedge CLK) begin
    if (ibus_addr !== req_addr || req_done) begin
      req_addr  = ibus_addr;
      wait_left = 2'(draw_bits(2));
      req_done  = 1'b0;
    end
    if (wait_left != 2'd0) begin
      ibus_busy <= 1'b1;
      wait_left = wait_left - 2'd1;
    end else begin
      ibus_busy <= 1'b0;
      req_done = (ibus_ren === 1'b1);
    end
    ibus_rdata <= mem_word(ibus_addr);
  end

  // compare each retire against the ISA model
  always @(negedge CLK) begin
    neg_count = neg_count + 1;
    if (!done && neg_count >= 2) begin
      // ren low while reset is held and high from the first edge after it
      check_value("ibus_ren", ibus_ren, (neg_count > RESET_CYCLES + 1) ? 32'd1 : 32'd0);
      if (neg_count <= RESET_CYCLES + 2) begin
        // reset and first cycle after it
        check_value("retire.valid", retire.valid, 32'd0);
        // no fetch has completed yet so the bus still shows the reset vector
        check_value("ibus_addr", ibus_addr, RESET_PC);
      end else if (retire.valid === 1'b1) begin
        exp_rec = ref_step();
        if (n_retired == 0) check_value("first retire.pc", retire.pc, RESET_PC);
        check_value("retire.pc", retire.pc, exp_rec.pc);
        check_value("retire.instr", retire.instr, exp_rec.instr);
        check_value("retire.trap", retire.trap, exp_rec.trap);
        check_value("retire.rd", retire.rd, exp_rec.rd);
        check_value("retire.rd_data", retire.rd_data, exp_rec.rd_data);
        n_retired = n_retired + 1;
        if (n_retired == N_RETIRE) done = 1'b1;
      end
    end
  end

  initial begin
    nRST = 1'b1;
    lfsr = LFSR_SEED;
    for (int k = 0; k < 32; k++) begin
      ref_regs[k] = '0;
    end
    build_program();
    @(negedge CLK);
    nRST <= 1'b0;
    repeat (RESET_CYCLES) @(negedge CLK);
    nRST <= 1'b1;
    do @(posedge CLK); while (!done && neg_count < MAX_CYCLES);
    if (done) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display(">>> FAIL");
      $fatal(1, "timeout after %0d cycles, %0d of %0d instructions retired",
             neg_count, n_retired, N_RETIRE);
    end
  end

endmodule

/* tspp_core.sv */
`timescale 1ns/10ps

module tspp_core (
  input  logic              CLK,
  input  logic              nRST,
  // instruction bus, ren/busy handshake
  output tspp_pkg::addr_t   ibus_addr,
  output logic              ibus_ren,
  input  tspp_pkg::word_t   ibus_rdata,
  input  logic              ibus_busy,
  // one record per completed instruction
  output tspp_pkg::retire_t retire
);
  import tspp_pkg::*;

  // hazard unit to fetch
  logic pc_en;
  logic npc_sel;
  logic insert_priv_pc;
  logic if_ex_flush;
  logic iren;
  logic i_mem_busy;

  // execute to hazard unit and fetch
  logic  redirect;
  logic  trap;
  addr_t brj_addr;

  // predictor paths
  logic       predict_taken;
  addr_t      target_addr;
  addr_t      current_pc;
  bp_update_t bp_update;

  fetch_ex_t fetch_ex;

  tspp_branch_predictor #(
    .BTB_ENTRIES (16)
  ) i_predictor (
    .CLK           (CLK),
    .nRST          (nRST),
    .current_pc    (current_pc),
    .update        (bp_update),
    .predict_taken (predict_taken),
    .target_addr   (target_addr)
  );

  tspp_fetch_stage i_fetch (
    .CLK            (CLK),
    .nRST           (nRST),
    .pc_en          (pc_en),
    .npc_sel        (npc_sel),
    .insert_priv_pc (insert_priv_pc),
    .if_ex_flush    (if_ex_flush),
    .iren           (iren),
    .brj_addr       (brj_addr),
    .predict_taken  (predict_taken),
    .target_addr    (target_addr),
    .current_pc     (current_pc),
    .ibus_addr      (ibus_addr),
    .ibus_ren       (ibus_ren),
    .ibus_rdata     (ibus_rdata),
    .ibus_busy      (ibus_busy),
    .i_mem_busy     (i_mem_busy),
    .fetch_ex       (fetch_ex)
  );

  tspp_hazard_unit i_hazard (
    .CLK            (CLK),
    .nRST           (nRST),
    .i_mem_busy     (i_mem_busy),
    .redirect       (redirect),
    .trap           (trap),
    .pc_en          (pc_en),
    .npc_sel        (npc_sel),
    .insert_priv_pc (insert_priv_pc),
    .if_ex_flush    (if_ex_flush),
    .iren           (iren)
  );

  tspp_execute_stage i_execute (
    .CLK       (CLK),
    .nRST      (nRST),
    .fetch_ex  (fetch_ex),
    .redirect  (redirect),
    .trap      (trap),
    .brj_addr  (brj_addr),
    .bp_update (bp_update),
    .retire    (retire)
  );

endmodule

/* tspp_execute_stage.sv */
`timescale 1ns/10ps

module tspp_execute_stage (
  input  logic                 CLK,
  input  logic                 nRST,
  input  tspp_pkg::fetch_ex_t  fetch_ex,
  output logic                 redirect,
  output logic                 trap,
  output tspp_pkg::addr_t      brj_addr,
  output tspp_pkg::bp_update_t bp_update,
  output tspp_pkg::retire_t    retire
);
  import tspp_pkg::*;

  // decoded fields
  opcode_t    opcode;
  regidx_t    rd;
  regidx_t    rs1;
  regidx_t    rs2;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_b;
  word_t      imm_j;

  word_t   regs [32];
  word_t   rs1_data;
  word_t   rs2_data;
  logic    live;
  logic    wen;
  word_t   result;
  logic    is_ctrl;
  logic    taken;
  addr_t   ctrl_target;
  addr_t   actual_npc;
  addr_t   pred_npc;
  retire_t retire_next;

  assign opcode = fetch_ex.instr[6:0];
  assign rd     = fetch_ex.instr[11:7];
  assign funct3 = fetch_ex.instr[14:12];
  assign rs1    = fetch_ex.instr[19:15];
  assign rs2    = fetch_ex.instr[24:20];
  assign funct7 = fetch_ex.instr[31:25];

  assign imm_i = {{20{fetch_ex.instr[31]}}, fetch_ex.instr[31:20]};
  assign imm_u = {fetch_ex.instr[31:12], 12'b0};
  assign imm_b = {{19{fetch_ex.instr[31]}}, fetch_ex.instr[31], fetch_ex.instr[7],
                  fetch_ex.instr[30:25], fetch_ex.instr[11:8], 1'b0};
  assign imm_j = {{11{fetch_ex.instr[31]}}, fetch_ex.instr[31], fetch_ex.instr[19:12],
                  fetch_ex.instr[20], fetch_ex.instr[30:21], 1'b0};

  // x0 reads as zero regardless of array content
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // faulted tokens do no work, they only trap
  assign live = fetch_ex.token & ~fetch_ex.mal_insn;

  always_comb begin
    wen         = 1'b0;
    result      = '0;
    is_ctrl     = 1'b0;
    taken       = 1'b0;
    ctrl_target = fetch_ex.pc4;
    case (opcode)
      OP_IMM: begin
        if (funct3 == F3_ADD) begin
          wen    = 1'b1;
          result = rs1_data + imm_i;
        end
      end
      OP_REG: begin
        if (funct3 == F3_ADD && funct7 == F7_ADD) begin
          wen    = 1'b1;
          result = rs1_data + rs2_data;
        end else if (funct3 == F3_ADD && funct7 == F7_SUB) begin
          wen    = 1'b1;
          result = rs1_data - rs2_data;
        end
      end
      OP_LUI: begin
        wen    = 1'b1;
        result = imm_u;
      end
      OP_BRANCH: begin
        ctrl_target = fetch_ex.pc + imm_b;
        case (funct3)
          F3_BEQ: begin
            is_ctrl = 1'b1;
            taken   = (rs1_data == rs2_data);
          end
          F3_BNE: begin
            is_ctrl = 1'b1;
            taken   = (rs1_data != rs2_data);
          end
          F3_BLT: begin
            is_ctrl = 1'b1;
            taken   = ($signed(rs1_data) < $signed(rs2_data));
          end
          default: ;
        endcase
      end
      OP_JAL: begin
        is_ctrl     = 1'b1;
        taken       = 1'b1;
        ctrl_target = fetch_ex.pc + imm_j;
        wen         = 1'b1;
        result      = fetch_ex.pc4;
      end
      OP_JALR: begin
        if (funct3 == 3'b000) begin
          is_ctrl = 1'b1;
          taken   = 1'b1;
          // bit 0 cleared, bit 1 may still fault at the target
          ctrl_target = (rs1_data + imm_i) & ~32'd1;
          wen         = 1'b1;
          result      = fetch_ex.pc4;
        end
      end
      default: ;
    endcase
    // nothing happens for bubbles and faulted slots
    if (!live) begin
      wen     = 1'b0;
      is_ctrl = 1'b0;
      taken   = 1'b0;
    end
    // writes to x0 are dropped
    if (rd == '0) begin
      wen = 1'b0;
    end
  end

  // next pc as resolved vs. as fetch guessed it
  assign actual_npc = taken ? ctrl_target : fetch_ex.pc4;
  assign pred_npc   = fetch_ex.prediction ? fetch_ex.pred_target : fetch_ex.pc4;

  assign redirect = live & (actual_npc != pred_npc);
  assign trap     = fetch_ex.token & fetch_ex.mal_insn;
  assign brj_addr = actual_npc;

  // train the predictor with every resolved control transfer
  assign bp_update.valid  = is_ctrl;
  assign bp_update.pc     = fetch_ex.pc;
  assign bp_update.taken  = taken;
  assign bp_update.target = ctrl_target;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[rd] <= result;
    end
  end

  // rd and data read as zero when nothing is written
  always_comb begin
    retire_next.valid   = fetch_ex.token;
    retire_next.pc      = fetch_ex.pc;
    retire_next.instr   = fetch_ex.instr;
    retire_next.rd      = wen ? rd : '0;
    retire_next.rd_data = wen ? result : '0;
    retire_next.trap    = trap;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      retire <= '0;
    end else begin
      retire <= retire_next;
    end
  end

endmodule

/* tspp_hazard_unit.sv */
`timescale 1ns/10ps

module tspp_hazard_unit (
  input  logic CLK,
  input  logic nRST,
  // status from fetch and execute
  input  logic i_mem_busy,
  input  logic redirect,
  input  logic trap,
  // fetch control
  output logic pc_en,
  output logic npc_sel,
  output logic insert_priv_pc,
  output logic if_ex_flush,
  output logic iren
);

  logic iren_q;

  // fetching starts one edge after reset goes away
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      iren_q <= 1'b0;
    end else begin
      iren_q <= 1'b1;
    end
  end

  assign iren = iren_q;

  // trap wins over a mispredict in the same slot
  assign insert_priv_pc = trap;
  assign npc_sel        = redirect & ~trap;

  // the one younger slot is dropped on either event
  assign if_ex_flush = redirect | trap;

  // pc moves on a delivered word or on any redirect
  // a redirect while busy abandons the pending request
  assign pc_en = trap | redirect | (iren_q & ~i_mem_busy);

endmodule

/* tspp_fetch_stage.sv */
`timescale 1ns/10ps

module tspp_fetch_stage (
  input  logic                CLK,
  input  logic                nRST,
  // control from the hazard unit
  input  logic                pc_en,
  input  logic                npc_sel,
  input  logic                insert_priv_pc,
  input  logic                if_ex_flush,
  input  logic                iren,
  // resolved target from execute
  input  tspp_pkg::addr_t     brj_addr,
  // predictor lookup
  input  logic                predict_taken,
  input  tspp_pkg::addr_t     target_addr,
  output tspp_pkg::addr_t     current_pc,
  // instruction bus
  output tspp_pkg::addr_t     ibus_addr,
  output logic                ibus_ren,
  input  tspp_pkg::word_t     ibus_rdata,
  input  logic                ibus_busy,
  output logic                i_mem_busy,
  output tspp_pkg::fetch_ex_t fetch_ex
);
  import tspp_pkg::*;

  addr_t     pc;
  addr_t     pc4;
  addr_t     npc;
  logic      fetch_done;
  logic      mal_addr;
  fetch_ex_t fetch_rec;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= RESET_PC;
    end else if (pc_en) begin
      pc <= npc;
    end
  end

  assign pc4 = pc + 32'd4;

  // trap, then execute redirect, then prediction, then sequential
  always_comb begin
    if (insert_priv_pc) begin
      npc = TRAP_PC;
    end else if (npc_sel) begin
      npc = brj_addr;
    end else if (predict_taken) begin
      npc = target_addr;
    end else begin
      npc = pc4;
    end
  end

  assign current_pc = pc;

  // bus drive, read only
  assign ibus_addr  = pc;
  assign ibus_ren   = iren;
  assign i_mem_busy = ibus_busy;

  // word arrives when ren is up and memory is not waiting
  assign fetch_done = ibus_ren & ~ibus_busy;
  // low two pc bits set means the fetch faults in execute
  assign mal_addr   = (pc[1:0] != 2'b00);

  always_comb begin
    fetch_rec.token       = 1'b1;
    fetch_rec.pc          = pc;
    fetch_rec.pc4         = pc4;
    fetch_rec.instr       = ibus_rdata;
    fetch_rec.prediction  = predict_taken;
    fetch_rec.pred_target = target_addr;
    fetch_rec.mal_insn    = mal_addr;
  end

  // flush or wait both leave an empty slot
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fetch_ex <= '0;
    end else if (if_ex_flush || !fetch_done) begin
      fetch_ex <= '0;
    end else begin
      fetch_ex <= fetch_rec;
    end
  end

endmodule

/* tspp_branch_predictor.sv */
`timescale 1ns/10ps

module tspp_branch_predictor #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  tspp_pkg::addr_t      current_pc,
  input  tspp_pkg::bp_update_t update,
  output logic                 predict_taken,
  output tspp_pkg::addr_t      target_addr
);
  import tspp_pkg::*;

  // index from word address bits, tag is the rest above
  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = 32 - IDX_W - 2;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    addr_t            target;
    logic [1:0]       cnt;
  } btb_entry_t;

  logic [BTB_ENTRIES-1:0] valid;
  btb_entry_t             btb [BTB_ENTRIES];

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  btb_entry_t       rd_entry;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;
  btb_entry_t       wr_entry;
  btb_entry_t       wr_next;
  logic             wr_hit;
  logic             wr_en;

  // lookup port, purely combinational from the fetch pc
  assign rd_idx        = current_pc[IDX_W+1:2];
  assign rd_tag        = current_pc[31:IDX_W+2];
  assign rd_entry      = btb[rd_idx];
  // taken only on tag hit with a counter in the upper half
  assign predict_taken = valid[rd_idx] && (rd_entry.tag == rd_tag) && rd_entry.cnt[1];
  assign target_addr   = rd_entry.target;

  // update port from execute
  assign wr_idx   = update.pc[IDX_W+1:2];
  assign wr_tag   = update.pc[31:IDX_W+2];
  assign wr_entry = btb[wr_idx];
  assign wr_hit   = valid[wr_idx] && (wr_entry.tag == wr_tag);

  always_comb begin
    wr_next = wr_entry;
    wr_en   = 1'b0;
    if (update.valid) begin
      if (wr_hit) begin
        wr_en = 1'b1;
        if (update.taken) begin
          wr_next.target = update.target;
          // saturate at strongly taken
          if (wr_entry.cnt != 2'b11) begin
            wr_next.cnt = wr_entry.cnt + 2'd1;
          end
        end else if (wr_entry.cnt != 2'b00) begin
          wr_next.cnt = wr_entry.cnt - 2'd1;
        end
      end else if (update.taken) begin
        // allocate on first taken, weakly taken
        wr_en          = 1'b1;
        wr_next.tag    = wr_tag;
        wr_next.target = update.target;
        wr_next.cnt    = 2'b10;
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      btb[wr_idx] <= wr_next;
    end
  end

endmodule

/* tspp_pkg.sv */
package tspp_pkg;

  // data and address widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  regidx_t;
  typedef logic [6:0]  opcode_t;

  // major opcodes of the supported subset
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;

  // funct3 / funct7 codes that execute decodes
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // first fetch address out of reset
  localparam addr_t RESET_PC = 32'h0000_0200;
  // handler entry for misaligned fetches
  localparam addr_t TRAP_PC = 32'h0000_0100;
  // addi x0, x0, 0
  localparam word_t NOP_INSTR = 32'h0000_0013;

  // fetch/execute register, all zero means empty slot
  typedef struct packed {
    logic  token;
    addr_t pc;
    addr_t pc4;
    word_t instr;
    logic  prediction;
    addr_t pred_target;
    logic  mal_insn;
  } fetch_ex_t;

  // one record per completed instruction
  typedef struct packed {
    logic    valid;
    addr_t   pc;
    word_t   instr;
    regidx_t rd;
    word_t   rd_data;
    logic    trap;
  } retire_t;

  // outcome of a resolved branch or jump
  typedef struct packed {
    logic  valid;
    addr_t pc;
    logic  taken;
    addr_t target;
  } bp_update_t;

endpackage
